// ==== verilog/synth_config_pkg.sv ====
`default_nettype none

package synth_config_pkg;

  // System timing.
  localparam int SYSTEM_CLOCK = 50_000_000;
  localparam int SAMPLE_RATE  = 48_000;

  // Widths of the voice datapath.
  localparam int AUDIO_BIT_WIDTH = 16;
  localparam int PERIOD_WIDTH    = 16;
  localparam int PERCENT_WIDTH   = 8;
  localparam int PHASE_WIDTH     = 16;
  localparam int GAIN_WIDTH      = 8;

  typedef logic [PERCENT_WIDTH-1:0]          percent_t;  // Duty as n/256.
  typedef logic [PHASE_WIDTH-1:0]            phase_t;    // Segment fraction, n/65536.
  typedef logic signed [AUDIO_BIT_WIDTH-1:0] audio_t;
  typedef logic [GAIN_WIDTH-1:0]             gain_t;     // Gain as n/256.

  // Largest positive level any wave reaches.
  localparam audio_t FULL_SCALE = 16'sd32767;

  // All three waves of one oscillator, sampled together.
  typedef struct packed {
    audio_t sine;
    audio_t pulse;
    audio_t triangle;
  } wave_set_t;

  typedef struct packed {
    gain_t sine_gain;
    gain_t pulse_gain;
    gain_t triangle_gain;
  } mix_gains_t;

endpackage : synth_config_pkg

`default_nettype wire

// ==== verilog/oscillator_pkg.sv ====
`default_nettype none

package oscillator_pkg;

  import synth_config_pkg::*;

  // Rising part of the cycle first, then the falling part.
  typedef enum logic {
    FRONT = 1'b0,
    BACK  = 1'b1
  } osc_segment_t;

  // Where the oscillator sits inside its cycle.
  typedef struct packed {
    osc_segment_t segment;
    phase_t       phase;
  } osc_position_t;

endpackage : oscillator_pkg

`default_nettype wire

// ==== verilog/phase_divider.sv ====
`timescale 1ns/100ps
`default_nettype none

module phase_divider
  import synth_config_pkg::*;
(
  input  logic [PERIOD_WIDTH-1:0] dividend,
  input  logic [PERIOD_WIDTH-1:0] divisor,
  output phase_t                  quotient
);

  // One spare bit so the shifted remainder never overflows.
  logic [PERIOD_WIDTH:0] remainder;
  phase_t                fraction;
  logic                  divisor_zero;
  logic                  whole_segment;

  assign divisor_zero  = (divisor == '0);
  assign whole_segment = (dividend >= divisor);

  // Restoring long division producing only the fractional bits.
  // Valid while dividend < divisor; the other cases are caught below.
  always_comb begin
    remainder = {1'b0, dividend};
    fraction  = '0;
    for (int i = PHASE_WIDTH - 1; i >= 0; i--) begin
      remainder = remainder << 1;
      if (remainder >= {1'b0, divisor}) begin
        remainder   = remainder - {1'b0, divisor};
        fraction[i] = 1'b1;
      end
    end
  end

  always_comb begin
    if (divisor_zero) begin
      quotient = '0;
    end else if (whole_segment) begin
      quotient = '1;                          // Saturate.
    end else begin
      quotient = fraction;
    end
  end

endmodule : phase_divider

`default_nettype wire

// ==== verilog/waveform_shaper.sv ====
`timescale 1ns/100ps
`default_nettype none

module waveform_shaper
  import synth_config_pkg::*;
  import oscillator_pkg::*;
(
  input  osc_position_t position,
  output wave_set_t     waves
);

  // Slope of the triangle, 2A per segment.
  localparam logic [PHASE_WIDTH-1:0] RAMP_SLOPE = 16'd65534;
  localparam logic [PHASE_WIDTH:0]   PHASE_ONE  = 17'd65536;

  logic [2*PHASE_WIDTH-1:0]          ramp_product;
  logic [PHASE_WIDTH-1:0]            ramp;
  logic signed [AUDIO_BIT_WIDTH:0]   ramp_signed;
  logic signed [AUDIO_BIT_WIDTH:0]   triangle_wide;

  logic [PHASE_WIDTH:0]              one_minus_phase;
  logic [2*PHASE_WIDTH:0]            parabola_product;
  logic [PHASE_WIDTH:0]              parabola;
  logic [2*PHASE_WIDTH:0]            sine_product;
  audio_t                            sine_magnitude;

  // Triangle ramp, 0 up to just under 2A across the segment.
  assign ramp_product = RAMP_SLOPE * position.phase;
  assign ramp         = ramp_product[2*PHASE_WIDTH-1 -: PHASE_WIDTH];
  assign ramp_signed  = $signed({1'b0, ramp});

  // 4p(1-p) in 16 bit fixed point, peaks at exactly 1.0.
  assign one_minus_phase  = PHASE_ONE - {1'b0, position.phase};
  assign parabola_product = position.phase * one_minus_phase;
  assign parabola         = parabola_product[2*PHASE_WIDTH-2 -: PHASE_WIDTH+1];

  // Scale to full amplitude.
  assign sine_product   = parabola * FULL_SCALE;
  assign sine_magnitude = sine_product[2*PHASE_WIDTH-1 -: AUDIO_BIT_WIDTH];

  always_comb begin
    if (position.segment == FRONT) begin
      triangle_wide = ramp_signed - FULL_SCALE;   // Rising from -A.
      waves.pulse   = FULL_SCALE;
      waves.sine    = sine_magnitude;
    end else begin
      triangle_wide = FULL_SCALE - ramp_signed;   // Falling from +A.
      waves.pulse   = -FULL_SCALE;
      waves.sine    = -sine_magnitude;
    end
  end

  // Range is within -A..A, so the top bit carries no information.
  assign waves.triangle = triangle_wide[AUDIO_BIT_WIDTH-1:0];

endmodule : waveform_shaper

`default_nettype wire

// ==== verilog/oscillator.sv ====
`timescale 1ns/100ps
`default_nettype none

module oscillator
  import synth_config_pkg::*;
  import oscillator_pkg::*;
#(
  parameter int GENERATION_TICKS = SYSTEM_CLOCK / SAMPLE_RATE
) (
  input  logic                    clock_50_000_000,
  input  logic                    reset_l,
  input  logic                    clear,
  input  logic [PERIOD_WIDTH-1:0] period,
  input  percent_t                duty_cycle,
  output wave_set_t               waves,
  output logic                    sample_tick
);

  localparam int PRESCALE_WIDTH = (GENERATION_TICKS > 1) ? $clog2(GENERATION_TICKS) : 1;
  localparam logic [PRESCALE_WIDTH-1:0] PRESCALE_LAST = PRESCALE_WIDTH'(GENERATION_TICKS - 1);

  osc_segment_t                          segment;
  logic [PERIOD_WIDTH-1:0]               target [2];  // Length of each segment in counts.
  logic [PERIOD_WIDTH-1:0]               count;
  logic [PRESCALE_WIDTH-1:0]             prescaler;
  logic [PERIOD_WIDTH+PERCENT_WIDTH-1:0] duty_product;
  logic [PERIOD_WIDTH-1:0]               duty_ticks;
  logic [PERIOD_WIDTH-1:0]               current_target;
  logic                                  prescale_done;
  logic                                  segment_done;
  phase_t                                phase;
  osc_position_t                         position;

  // period * duty / 256, rounded down.
  assign duty_product = period * duty_cycle;
  assign duty_ticks   = duty_product[PERIOD_WIDTH+PERCENT_WIDTH-1 -: PERIOD_WIDTH];

  assign current_target = target[segment];
  assign prescale_done  = (prescaler == PRESCALE_LAST);

  // Empty segments pass in a single clock.
  assign segment_done = (current_target == '0) ||
                        (prescale_done && (count == current_target - 1'b1));

  always_ff @(posedge clock_50_000_000 or negedge reset_l) begin
    if (!reset_l) begin
      segment       <= FRONT;
      count         <= '0;
      prescaler     <= '0;
      target[FRONT] <= '0;
      target[BACK]  <= '0;
      sample_tick   <= 1'b0;
    end else if (clear) begin
      segment       <= FRONT;
      count         <= '0;
      prescaler     <= '0;
      target[FRONT] <= duty_ticks;
      target[BACK]  <= period - duty_ticks;
      sample_tick   <= 1'b0;
    end else if (segment_done) begin
      segment     <= segment.next();
      count       <= '0;
      prescaler   <= '0;
      sample_tick <= 1'b1;
    end else if (prescale_done) begin
      prescaler   <= '0;
      count       <= count + 1'b1;
      sample_tick <= 1'b1;
    end else begin
      prescaler   <= prescaler + 1'b1;
      sample_tick <= 1'b0;
    end
  end

  phase_divider i_phase_divider (
    .dividend (count),
    .divisor  (current_target),
    .quotient (phase)
  );

  assign position = '{segment: segment, phase: phase};

  waveform_shaper i_waveform_shaper (
    .position (position),
    .waves    (waves)
  );

endmodule : oscillator

`default_nettype wire

// ==== verilog/voice_mixer.sv ====
`timescale 1ns/100ps
`default_nettype none

module voice_mixer
  import synth_config_pkg::*;
(
  input  logic       clock_50_000_000,
  input  logic       reset_l,
  input  logic       sample_tick,
  input  wave_set_t  waves,
  input  mix_gains_t gains,
  output audio_t     sample,
  output logic       sample_valid
);

  // Signed wave times unsigned gain, plus headroom for three terms.
  localparam int PRODUCT_WIDTH = AUDIO_BIT_WIDTH + GAIN_WIDTH + 1;
  localparam int SUM_WIDTH     = PRODUCT_WIDTH + 2;

  localparam logic signed [SUM_WIDTH-1:0] SAMPLE_MAX = SUM_WIDTH'(32767);
  localparam logic signed [SUM_WIDTH-1:0] SAMPLE_MIN = -SUM_WIDTH'(32768);

  logic signed [SUM_WIDTH-1:0] sum;
  logic signed [SUM_WIDTH-1:0] scaled;
  audio_t                      clipped;

  function automatic logic signed [SUM_WIDTH-1:0] weigh(audio_t level, gain_t gain);
    logic signed [GAIN_WIDTH:0] signed_gain;
    signed_gain = $signed({1'b0, gain});
    return level * signed_gain;
  endfunction

  assign sum = weigh(waves.sine, gains.sine_gain) +
               weigh(waves.pulse, gains.pulse_gain) +
               weigh(waves.triangle, gains.triangle_gain);

  assign scaled = sum >>> GAIN_WIDTH;       // Floor of sum / 256.

  always_comb begin
    if (scaled > SAMPLE_MAX) begin
      clipped = 16'sh7fff;
    end else if (scaled < SAMPLE_MIN) begin
      clipped = 16'sh8000;
    end else begin
      clipped = scaled[AUDIO_BIT_WIDTH-1:0];
    end
  end

  always_ff @(posedge clock_50_000_000 or negedge reset_l) begin
    if (!reset_l) begin
      sample       <= '0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= sample_tick;
      if (sample_tick) sample <= clipped;  // Held between ticks.
    end
  end

endmodule : voice_mixer

`default_nettype wire

// ==== verilog/synth_voice.sv ====
`timescale 1ns/100ps
`default_nettype none

module synth_voice
  import synth_config_pkg::*;
#(
  parameter int GENERATION_TICKS = SYSTEM_CLOCK / SAMPLE_RATE
) (
  input  logic                    clock_50_000_000,
  input  logic                    reset_l,
  input  logic                    clear,
  input  logic [PERIOD_WIDTH-1:0] period,
  input  percent_t                duty_cycle,
  input  mix_gains_t              gains,
  output wave_set_t               waves,
  output audio_t                  sample,
  output logic                    sample_valid
);

  logic sample_tick;

  oscillator #(
    .GENERATION_TICKS (GENERATION_TICKS)
  ) i_oscillator (
    .clock_50_000_000 (clock_50_000_000),
    .reset_l          (reset_l),
    .clear            (clear),
    .period           (period),
    .duty_cycle       (duty_cycle),
    .waves            (waves),
    .sample_tick      (sample_tick)
  );

  // Samples the waves on every oscillator step.
  voice_mixer i_voice_mixer (
    .clock_50_000_000 (clock_50_000_000),
    .reset_l          (reset_l),
    .sample_tick      (sample_tick),
    .waves            (waves),
    .gains            (gains),
    .sample           (sample),
    .sample_valid     (sample_valid)
  );

endmodule : synth_voice

`default_nettype wire

// ==== include/voice_model.svh ====
`ifndef VOICE_MODEL_SVH
`define VOICE_MODEL_SVH

// Reference model of one voice. Expects synth_config_pkg and
// oscillator_pkg to be imported where this is included.

function automatic logic [PERIOD_WIDTH-1:0] model_front_target(
    input logic [PERIOD_WIDTH-1:0] period,
    input percent_t                duty);
  longint product;
  product = longint'(period) * longint'(duty);
  return PERIOD_WIDTH'(product >> PERCENT_WIDTH);
endfunction

function automatic logic [PERIOD_WIDTH-1:0] model_back_target(
    input logic [PERIOD_WIDTH-1:0] period,
    input percent_t                duty);
  return period - model_front_target(period, duty);
endfunction

function automatic phase_t model_phase(input longint count, input longint target);
  longint q;
  if (target == 0) return '0;
  q = (count * 65536) / target;
  if (q > 65535) return '1;
  return phase_t'(q);
endfunction

function automatic audio_t model_triangle(input osc_segment_t seg, input phase_t phase);
  longint ramp;
  ramp = (longint'(65534) * longint'(phase)) >> 16;
  if (seg == FRONT) return audio_t'(ramp - 32767);
  return audio_t'(32767 - ramp);
endfunction

function automatic audio_t model_pulse(input osc_segment_t seg);
  return (seg == FRONT) ? FULL_SCALE : -FULL_SCALE;
endfunction

function automatic audio_t model_sine(input osc_segment_t seg, input phase_t phase);
  longint parabola;
  longint magnitude;
  parabola  = (longint'(phase) * (65536 - longint'(phase))) >> 14;
  magnitude = (longint'(32767) * parabola) >> 16;
  if (seg == FRONT) return audio_t'(magnitude);
  return audio_t'(-magnitude);
endfunction

function automatic wave_set_t model_waves(input osc_segment_t seg, input phase_t phase);
  wave_set_t w;
  w.sine     = model_sine(seg, phase);
  w.pulse    = model_pulse(seg);
  w.triangle = model_triangle(seg, phase);
  return w;
endfunction

// Weighted sum, floor of / 256, then clipped to the sample range.
function automatic audio_t model_mix(input wave_set_t w, input mix_gains_t g);
  longint sum;
  sum = longint'(w.sine) * longint'(g.sine_gain) +
        longint'(w.pulse) * longint'(g.pulse_gain) +
        longint'(w.triangle) * longint'(g.triangle_gain);
  sum = sum >>> 8;
  if (sum > 32767) return 16'sh7fff;
  if (sum < -32768) return 16'sh8000;
  return audio_t'(sum);
endfunction

`endif

// ==== sim/tb_synth_voice.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_synth_voice
  import synth_config_pkg::*;
  import oscillator_pkg::*;
();

  `include "voice_model.svh"

  localparam int TICKS           = 4;     // Clocks per count step.
  localparam int SEGMENT_TIMEOUT = 2000;  // Longest segment is 200 * 4 clocks.
  localparam int SAMPLE_TIMEOUT  = 64;

  logic                    clock_50_000_000 = 1'b0;
  logic                    reset_l;
  logic                    clear;
  logic [PERIOD_WIDTH-1:0] period;
  percent_t                duty_cycle;
  mix_gains_t              gains;
  wave_set_t               waves;
  audio_t                  sample;
  logic                    sample_valid;

  int error_count = 0;
  int check_count = 0;
  int test_count  = 0;
  int seed_value;

  // Reference state of the oscillator and the mixer.
  osc_segment_t m_segment;
  int           m_count;
  int           m_prescale;
  int           m_front_target;
  int           m_back_target;
  logic         m_tick;
  audio_t       exp_sample;
  logic         exp_valid;
  logic         model_ready = 1'b0;

  synth_voice #(
    .GENERATION_TICKS (TICKS)
  ) i_dut (
    .clock_50_000_000 (clock_50_000_000),
    .reset_l          (reset_l),
    .clear            (clear),
    .period           (period),
    .duty_cycle       (duty_cycle),
    .gains            (gains),
    .waves            (waves),
    .sample           (sample),
    .sample_valid     (sample_valid)
  );

  always #4 clock_50_000_000 = ~clock_50_000_000;

  function automatic int active_target();
    return (m_segment == FRONT) ? m_front_target : m_back_target;
  endfunction

  function automatic wave_set_t expected_waves();
    return model_waves(m_segment, model_phase(longint'(m_count), longint'(active_target())));
  endfunction

  // Segment rules applied to the inputs seen at each rising edge.
  always @(posedge clock_50_000_000) begin
    if (!reset_l) begin
      m_segment      = FRONT;
      m_count        = 0;
      m_prescale     = 0;
      m_front_target = 0;
      m_back_target  = 0;
      m_tick         = 1'b0;
      exp_sample     = '0;
      exp_valid      = 1'b0;
    end else begin
      exp_valid = m_tick;
      if (m_tick) exp_sample = model_mix(expected_waves(), gains);
      if (clear) begin
        m_segment      = FRONT;
        m_count        = 0;
        m_prescale     = 0;
        m_front_target = int'(model_front_target(period, duty_cycle));
        m_back_target  = int'(model_back_target(period, duty_cycle));
        m_tick         = 1'b0;
      end else if (active_target() == 0 ||
                   (m_prescale == TICKS - 1 && m_count == active_target() - 1)) begin
        m_segment  = (m_segment == FRONT) ? BACK : FRONT;
        m_count    = 0;
        m_prescale = 0;
        m_tick     = 1'b1;  // Switch edge also ticks.
      end else if (m_prescale == TICKS - 1) begin
        m_prescale = 0;
        m_count++;
        m_tick = 1'b1;
      end else begin
        m_prescale++;
        m_tick = 1'b0;
      end
    end
    model_ready = 1'b1;
  end

  task automatic check_waves(input string what, input wave_set_t expected,
                             input wave_set_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch at %0t: %s expected sine/pulse/triangle %0d/%0d/%0d got %0d/%0d/%0d",
               $time, what, expected.sine, expected.pulse, expected.triangle,
               actual.sine, actual.pulse, actual.triangle);
    end
  endtask

  task automatic check_sample(input string what, input audio_t expected, input audio_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch at %0t: %s expected %0d got %0d", $time, what, expected, actual);
    end
  endtask

  task automatic check_strobe(input string what, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch at %0t: %s expected %b got %b", $time, what, expected, actual);
    end
  endtask

  task automatic check_duration(input string what, input int expected, input int actual);
    check_count++;
    if (actual != expected) begin
      error_count++;
      $display("Mismatch at %0t: %s expected %0d got %0d", $time, what, expected, actual);
    end
  endtask

  // Outputs are compared mid-cycle, away from the active edge.
  always @(negedge clock_50_000_000) begin
    if (model_ready) begin
      check_waves("waves", expected_waves(), waves);
      check_strobe("sample_valid", exp_valid, sample_valid);
      check_sample("sample", exp_sample, sample);
    end
  end

  task automatic report_timeout(input string what);
    error_count++;
    $display("Timeout at %0t: %s", $time, what);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    test_count++;
    $display("Test %0d %s done with %0d errors", test_count, name, error_count - errors_before);
  endtask

  task automatic wait_clocks(input int clocks);
    repeat (clocks) @(posedge clock_50_000_000);
  endtask

  task automatic apply_clear(input logic [PERIOD_WIDTH-1:0] new_period, input percent_t duty);
    @(posedge clock_50_000_000);
    period     <= new_period;
    duty_cycle <= duty;
    clear      <= 1'b1;
    @(posedge clock_50_000_000);
    clear <= 1'b0;
  endtask

  task automatic wait_for_pulse(input audio_t level, input string what);
    int waited;
    waited = 0;
    @(negedge clock_50_000_000);
    while (waves.pulse !== level && waited < SEGMENT_TIMEOUT) begin
      @(negedge clock_50_000_000);
      waited++;
    end
    if (waves.pulse !== level) report_timeout(what);
  endtask

  // Starts on a falling edge where the pulse is at level.
  task automatic measure_run(input audio_t level, output int clocks);
    clocks = 0;
    while (waves.pulse === level && clocks < SEGMENT_TIMEOUT) begin
      clocks++;
      @(negedge clock_50_000_000);
    end
    if (clocks >= SEGMENT_TIMEOUT) report_timeout("pulse level never changed");
  endtask

  task automatic check_runs(input logic [PERIOD_WIDTH-1:0] p, input percent_t d);
    int front_target;
    int back_target;
    int high_clocks;
    int low_clocks;
    front_target = int'(model_front_target(p, d));
    back_target  = int'(model_back_target(p, d));
    measure_run(FULL_SCALE, high_clocks);
    measure_run(-FULL_SCALE, low_clocks);
    if (front_target != 0) check_duration("FRONT clocks", front_target * TICKS, high_clocks);
    if (back_target != 0) check_duration("BACK clocks", back_target * TICKS, low_clocks);
  endtask

  task automatic test_reset_state();
    int           errors_before;
    osc_segment_t expected_segment;
    errors_before = error_count;
    for (int i = 0; i < 8; i++) begin
      @(negedge clock_50_000_000);
      check_waves("waves in reset", model_waves(FRONT, '0), waves);
      check_sample("sample in reset", '0, sample);
      check_strobe("sample_valid in reset", 1'b0, sample_valid);
    end
    @(posedge clock_50_000_000);
    reset_l <= 1'b1;
    expected_segment = FRONT;
    for (int i = 0; i < 6; i++) begin
      @(negedge clock_50_000_000);
      check_waves("waves after reset", model_waves(expected_segment, '0), waves);
      if (i < 2) check_strobe("sample_valid before first tick", 1'b0, sample_valid);
      expected_segment = (expected_segment == FRONT) ? BACK : FRONT;  // Empty segments.
    end
    finish_test("reset state", errors_before);
  endtask

  task automatic test_duty_split();
    int                      errors_before;
    logic [PERIOD_WIDTH-1:0] p;
    percent_t                d;
    errors_before = error_count;
    for (int n = 0; n < 6; n++) begin
      p = PERIOD_WIDTH'($urandom_range(200, 2));
      d = (n == 0) ? '0 : percent_t'($urandom_range(255, 0));
      apply_clear(p, d);
      wait_for_pulse(-FULL_SCALE, "no BACK segment after clear");
      wait_for_pulse(FULL_SCALE, "no FRONT segment after BACK");
      check_runs(p, d);
    end
    finish_test("duty split", errors_before);
  endtask

  task automatic test_wave_shapes();
    int                      errors_before;
    logic [PERIOD_WIDTH-1:0] p;
    errors_before = error_count;
    for (int n = 0; n < 3; n++) begin
      p = PERIOD_WIDTH'($urandom_range(200, 2));
      apply_clear(p, percent_t'($urandom_range(255, 0)));
      wait_clocks(2 * TICKS * int'(p) + 8);
      // A new setting without a clear must leave the waves alone.
      @(posedge clock_50_000_000);
      period     <= PERIOD_WIDTH'($urandom_range(200, 2));
      duty_cycle <= percent_t'($urandom_range(255, 0));
      wait_clocks(TICKS * int'(p));
    end
    finish_test("wave shapes", errors_before);
  endtask

  task automatic test_mixing();
    int                      errors_before;
    logic [PERIOD_WIDTH-1:0] p;
    errors_before = error_count;
    for (int n = 0; n < 5; n++) begin
      @(posedge clock_50_000_000);
      gains <= (n == 0) ? mix_gains_t'(24'hffffff) : mix_gains_t'(24'($urandom));
      p = PERIOD_WIDTH'($urandom_range(200, 2));
      apply_clear(p, percent_t'($urandom_range(255, 0)));
      wait_clocks(2 * TICKS * int'(p) + 8);
    end
    finish_test("mixing and saturation", errors_before);
  endtask

  task automatic test_clear_mid_segment();
    int                      errors_before;
    logic [PERIOD_WIDTH-1:0] p;
    percent_t                d;
    errors_before = error_count;
    for (int n = 0; n < 4; n++) begin
      apply_clear(PERIOD_WIDTH'($urandom_range(200, 2)), percent_t'($urandom_range(255, 0)));
      wait_clocks($urandom_range(120, 5));
      p = PERIOD_WIDTH'($urandom_range(200, 2));
      d = percent_t'($urandom_range(255, 0));
      apply_clear(p, d);
      @(negedge clock_50_000_000);
      check_waves("waves after clear", model_waves(FRONT, '0), waves);
      check_runs(p, d);
    end
    finish_test("clear mid-segment", errors_before);
  endtask

  task automatic test_sample_cadence();
    int errors_before;
    int waited;
    int interval;
    errors_before = error_count;
    apply_clear(PERIOD_WIDTH'($urandom_range(12, 2)), 8'd128);  // Both segments nonempty.
    wait_clocks(1);  // A strobe from before the clear can still be showing.
    waited = 0;
    @(negedge clock_50_000_000);
    while (sample_valid !== 1'b1 && waited < SAMPLE_TIMEOUT) begin
      @(negedge clock_50_000_000);
      waited++;
    end
    if (sample_valid !== 1'b1) report_timeout("no sample_valid after clear");
    for (int n = 0; n < 24; n++) begin
      interval = 0;
      do begin
        @(negedge clock_50_000_000);
        interval++;
      end while (sample_valid !== 1'b1 && interval < SAMPLE_TIMEOUT);
      check_duration("sample_valid interval", TICKS, interval);
    end
    finish_test("sample cadence", errors_before);
  endtask

  initial begin
    seed_value = $urandom(23);
    reset_l    = 1'b0;
    clear      = 1'b0;
    period     = '0;
    duty_cycle = '0;
    gains      = '{sine_gain: 8'd64, pulse_gain: 8'd64, triangle_gain: 8'd64};
    test_reset_state();
    test_duty_split();
    test_wave_shapes();
    test_mixing();
    test_clear_mid_segment();
    test_sample_cadence();
    $display("Ran %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : tb_synth_voice

`default_nettype wire

// ==== all.f ====
+incdir+include
verilog/synth_config_pkg.sv
verilog/oscillator_pkg.sv
verilog/phase_divider.sv
verilog/waveform_shaper.sv
verilog/oscillator.sv
verilog/voice_mixer.sv
verilog/synth_voice.sv
sim/tb_synth_voice.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the voice testbench with Verilator, run it and search the log for the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
  --top-module tb_synth_voice --Mdir obj_dir -o tb_synth_voice \
  -f all.f > build.log 2>&1 &&
  ./obj_dir/tb_synth_voice > sim.log 2>&1 &&
  grep -qx "TB PASSED" sim.log &&
  { echo "Simulation passed."; exit 0; } ||
  { echo "Simulation failed, see build.log and sim.log."; exit 1; }
